//--- include/scdTbModel.svh
`ifndef SCD_TB_MODEL_SVH
`define SCD_TB_MODEL_SVH

// Needs scdPkg and scdFlagPkg imported in the including scope
typedef logic [ExpWidthDefault-1:0] modelExpT;

function automatic modelExpT modelOpA(expCmdT cmd, logic [0:ArWidth-1] ar, modelExpT fe);
  case (cmd.aSel)
    aFe:     return fe;
    aArPos:  return modelExpT'(ar[0:5]);
    aArExp:  return modelExpT'(ar[1:8] ^ {8{ar[0]}});
    aMagic:  return modelExpT'($signed(cmd.magic));
    default: return '0;
  endcase
endfunction

function automatic modelExpT modelOpB(expCmdT cmd, logic [0:ArWidth-1] ar, modelExpT sc);
  case (cmd.bSel)
    bSc:       return sc;
    bArSize:   return modelExpT'(ar[6:11]);
    bArSigned: return modelExpT'({ar[0], ar[0:8]});
    default:   return modelExpT'($signed(cmd.magic));
  endcase
endfunction

function automatic modelExpT modelScad(expCmdT cmd, logic [0:ArWidth-1] ar,
                                       modelExpT fe, modelExpT sc);
  modelExpT a;
  modelExpT b;
  a = modelOpA(cmd, ar, fe);
  b = modelOpB(cmd, ar, sc);
  case (cmd.func)
    funcA:             return a;
    funcAMinusBMinus1: return a - b - modelExpT'(1);
    funcAPlusB:        return a + b;
    funcAMinus1:       return a - modelExpT'(1);
    funcAPlus1:        return a + modelExpT'(1);
    funcAMinusB:       return a - b;
    funcOr:            return a | b;
    default:           return a & b;
  endcase
endfunction

function automatic modelExpT modelScNext(expCmdT cmd, logic [0:ArWidth-1] ar,
                                         modelExpT fe, modelExpT sc, modelExpT scad);
  case (cmd.scSel)
    scFe:    return fe;
    scScad:  return scad;
    scAr:    return modelExpT'({ar[18], ar[18], ar[28:35]});
    default: return sc;
  endcase
endfunction

function automatic pcFlagsT modelFlagsNext(pcFlagsT f, flagCmdT cmd, logic [0:ArWidth-1] ar);
  pcFlagsT n;
  logic    ad;
  logic    mg;
  ad = cmd.setAdFlags && !cmd.piCycle;
  mg = cmd.pcfMagic && !cmd.piCycle;
  if (cmd.loadFlags) begin
    n = '{ov: ar[0], cry0: ar[1], cry1: ar[2], fov: ar[3],
          fxu: ar[11], divChk: ar[12], fpd: ar[4]};
  end else begin
    n.ov     = f.ov | (ad & cmd.adOverflow) | (mg & cmd.magic[0]);
    n.cry0   = f.cry0 | (ad & cmd.adCry0);
    n.cry1   = f.cry1 | (ad & cmd.adCry1);
    n.fov    = f.fov | (mg & cmd.magic[0]);
    n.fxu    = f.fxu | (mg & cmd.magic[5]);
    n.divChk = f.divChk | (mg & cmd.magic[6]);
    n.fpd    = (f.fpd & ~cmd.clrFpd) | (mg & cmd.magic[2]);
  end
  return n;
endfunction

function automatic logic [DiagWidth-1:0] modelDiag(modelExpT fe, modelExpT sc, modelExpT scad,
                                                  pcFlagsT f, logic rd, logic [2:0] sel);
  if (!rd) return '0;
  case (sel)
    3'd0:    return DiagWidth'(fe);
    3'd1:    return DiagWidth'(sc);
    3'd2:    return DiagWidth'({f.ov, f.cry0, f.cry1, f.fov, f.fxu, f.divChk, f.fpd});
    3'd3:    return DiagWidth'(scad);
    default: return '0;
  endcase
endfunction

`endif

//--- bench/scdTb.sv
`timescale 1ns/1ps

module scdTb
  import scdPkg::*;
  import scdFlagPkg::*;
();

  localparam int ExpWidth = 10;

  logic                 clk;
  logic                 rstN;
  expCmdT               expCmd;
  flagCmdT              flagCmd;
  logic [0:ArWidth-1]   ar;
  logic                 diagRead;
  diagSelT              diagSel;
  logic [ExpWidth-1:0]  scad;
  logic                 scadZero;
  logic [ExpWidth-1:0]  fe;
  logic [ExpWidth-1:0]  sc;
  pcFlagsT              flags;
  logic [DiagWidth-1:0] diagData;

  `include "scdTbModel.svh"

  modelExpT    mFe;
  modelExpT    mSc;
  pcFlagsT     mFlags;
  logic [31:0] rngState = 32'hdc31;
  string       curTest;
  int          errors = 0;
  int          testStartErrors = 0;
  int          testsPassed = 0;
  logic        timedOut = 1'b0;

  scdTop #(
    .ExpWidth(ExpWidth)
  ) dut_i (
    .clk     (clk),
    .rstN    (rstN),
    .expCmd  (expCmd),
    .flagCmd (flagCmd),
    .ar      (ar),
    .diagRead(diagRead),
    .diagSel (diagSel),
    .scad    (scad),
    .scadZero(scadZero),
    .fe      (fe),
    .sc      (sc),
    .flags   (flags),
    .diagData(diagData)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
  end

  // Upper half of the LCG state since its low bits repeat quickly
  function automatic logic [15:0] nextRand();
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return rngState[31:16];
  endfunction

  task automatic checkExp(string what, logic [ExpWidth-1:0] expected,
                          logic [ExpWidth-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", curTest, what, expected, actual);
      errors++;
    end
  endtask

  task automatic checkBit(string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %b actual %b", curTest, what, expected, actual);
      errors++;
    end
  endtask

  task automatic checkFlags(string what, pcFlagsT expected, pcFlagsT actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %b actual %b", curTest, what, expected, actual);
      errors++;
    end
  endtask

  task automatic checkDiag(string what, logic [DiagWidth-1:0] expected,
                           logic [DiagWidth-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", curTest, what, expected, actual);
      errors++;
    end
  endtask

  task automatic startTest(string name);
    curTest = name;
    testStartErrors = errors;
  endtask

  task automatic endTest();
    if (errors == testStartErrors) begin
      $display("Test %s passed", curTest);
      testsPassed++;
    end else begin
      $display("Test %s failed with %0d errors", curTest, errors - testStartErrors);
    end
  endtask

  task automatic randomAll();
    logic [15:0] r;
    r = nextRand();
    expCmd.func = scadFuncT'(r[2:0]);
    expCmd.aSel = scadASelT'(r[5:3] % 3'd5);
    expCmd.bSel = scadBSelT'(r[7:6]);
    expCmd.feLoad = r[8];
    expCmd.scSel = scSelT'(r[10:9]);
    diagRead = r[11];
    diagSel = diagSelT'(r[14:12]);
    r = nextRand();
    expCmd.magic = r[8:0];
    r = nextRand();
    flagCmd.setAdFlags = r[0];
    flagCmd.adOverflow = r[1];
    flagCmd.adCry0 = r[2];
    flagCmd.adCry1 = r[3];
    flagCmd.loadFlags = (r[5:4] == 2'b00);
    flagCmd.pcfMagic = r[6];
    flagCmd.clrFpd = r[7];
    flagCmd.piCycle = r[8] & r[9];
    flagCmd.magic = r[15:7];
    ar = {nextRand(), nextRand(), r[3:0]};
  endtask

  // Combinational outputs are checked mid-cycle and registers just after the edge
  task automatic runCycle();
    modelExpT expScad;
    modelExpT nextFe;
    modelExpT nextSc;
    pcFlagsT  nextFlags;
    #10;
    expScad = modelScad(expCmd, ar, mFe, mSc);
    checkExp("scad", expScad, scad);
    checkBit("scadZero", expScad == '0, scadZero);
    checkDiag("diagData", modelDiag(mFe, mSc, expScad, mFlags, diagRead, diagSel), diagData);
    nextFe = expCmd.feLoad ? expScad : mFe;
    nextSc = modelScNext(expCmd, ar, mFe, mSc, expScad);
    nextFlags = modelFlagsNext(mFlags, flagCmd, ar);
    @(posedge clk);
    #1;
    mFe = nextFe;
    mSc = nextSc;
    mFlags = nextFlags;
    checkExp("fe", mFe, fe);
    checkExp("sc", mSc, sc);
    checkFlags("flags", mFlags, flags);
    #1;
  endtask

  task automatic waitResetRelease(output logic ok);
    int cycles;
    cycles = 0;
    while (rstN !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    ok = (rstN === 1'b1);
    #2;
  endtask

  initial begin
    int   i;
    logic ok;
    expCmd = '0;
    flagCmd = '0;
    ar = '0;
    diagRead = 1'b0;
    diagSel = diagFe;
    mFe = '0;
    mSc = '0;
    mFlags = '0;
    waitResetRelease(ok);
    if (!ok) begin
      $display("Timed out waiting for reset release");
      timedOut = 1'b1;
    end else begin
      startTest("reset");
      checkExp("fe", '0, fe);
      checkExp("sc", '0, sc);
      checkFlags("flags", '0, flags);
      checkDiag("diagData", '0, diagData);
      endTest();

      startTest("scadFunctions");
      for (i = 0; i < 200; i++) begin
        randomAll();
        expCmd.func = scadFuncT'(i[2:0]);
        expCmd.aSel = scadASelT'(3'((i / 8) % 5));
        runCycle();
      end
      endTest();

      startTest("feScLoad");
      for (i = 0; i < 150; i++) begin
        randomAll();
        runCycle();
      end
      endTest();

      startTest("flagLoadSet");
      for (i = 0; i < 150; i++) begin
        randomAll();
        flagCmd.piCycle = 1'b0;
        runCycle();
      end
      endTest();

      startTest("piCycleFpdClear");
      for (i = 0; i < 40; i++) begin
        randomAll();
        flagCmd.loadFlags = 1'b0;
        flagCmd.clrFpd = 1'b0;
        flagCmd.piCycle = 1'b1;
        runCycle();
      end
      // Alternate a random flag load with a clrFpd cycle
      for (i = 0; i < 60; i++) begin
        randomAll();
        flagCmd.loadFlags = ~i[0];
        flagCmd.clrFpd = i[0];
        flagCmd.piCycle = 1'b0;
        runCycle();
      end
      endTest();

      startTest("diagRead");
      for (i = 0; i < 48; i++) begin
        randomAll();
        diagRead = i[0];
        diagSel = diagSelT'(i[3:1]);
        runCycle();
      end
      endTest();
    end
    $display("Tests passed %0d, errors %0d", testsPassed, errors);
    if (errors == 0 && !timedOut) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
logic/scdPkg.sv
logic/scdFlagPkg.sv
logic/scadAlu.sv
logic/expDatapath.sv
logic/pcFlags.sv
logic/diagReader.sv
logic/scdTop.sv
bench/scdTb.sv

//--- logic/diagReader.sv
`timescale 1ns/1ps

module diagReader
  import scdPkg::*;
  import scdFlagPkg::*;
#(
  parameter int ExpWidth = ExpWidthDefault
) (
  input  logic [ExpWidth-1:0]  fe,
  input  logic [ExpWidth-1:0]  sc,
  input  logic [ExpWidth-1:0]  scad,
  input  pcFlagsT              flags,
  input  logic                 diagRead,
  input  diagSelT              diagSel,
  output logic [DiagWidth-1:0] diagData
);

  logic [DiagWidth-1:0] feWord;
  logic [DiagWidth-1:0] scWord;
  logic [DiagWidth-1:0] scadWord;
  logic [DiagWidth-1:0] flagWord;

  // Everything sits right-justified in the read word
  assign feWord   = DiagWidth'(fe);
  assign scWord   = DiagWidth'(sc);
  assign scadWord = DiagWidth'(scad);
  assign flagWord = DiagWidth'(flags);

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        diagFe:    diagData = feWord;
        diagSc:    diagData = scWord;
        diagFlags: diagData = flagWord;
        diagScad:  diagData = scadWord;
        default:   diagData = '0;
      endcase
    end
  end

endmodule

//--- logic/expDatapath.sv
`timescale 1ns/1ps

module expDatapath
  import scdPkg::*;
#(
  parameter int ExpWidth = ExpWidthDefault
) (
  input  logic                clk,
  input  logic                rstN,
  input  expCmdT              cmd,
  input  logic [0:ArWidth-1]  ar,
  output logic [ExpWidth-1:0] scad,
  output logic                scadZero,
  output logic [ExpWidth-1:0] fe,
  output logic [ExpWidth-1:0] sc
);

  logic [ExpWidth-1:0] magicExt;
  logic [ExpWidth-1:0] arPos;
  logic [ExpWidth-1:0] arExp;
  logic [ExpWidth-1:0] arSize;
  logic [ExpWidth-1:0] arSigned;
  logic [ExpWidth-1:0] arSc;
  logic [ExpWidth-1:0] opA;
  logic [ExpWidth-1:0] opB;
  logic [ExpWidth-1:0] scNext;

  // AR fields as seen by the operand muxes
  assign magicExt = ExpWidth'($signed(cmd.magic));
  assign arPos    = ExpWidth'(ar[0:5]);
  // Exponent magnitude, ones complemented for negative numbers
  assign arExp    = ExpWidth'(ar[1:8] ^ {8{ar[0]}});
  assign arSize   = ExpWidth'(ar[6:11]);
  assign arSigned = ExpWidth'($signed(ar[0:8]));
  // Right half count with AR18 as the sign
  assign arSc     = ExpWidth'($signed({ar[18], ar[28:35]}));

  always_comb begin
    case (cmd.aSel)
      aFe:     opA = fe;
      aArPos:  opA = arPos;
      aArExp:  opA = arExp;
      aMagic:  opA = magicExt;
      default: opA = '0;
    endcase
  end

  always_comb begin
    unique case (cmd.bSel)
      bSc:       opB = sc;
      bArSize:   opB = arSize;
      bArSigned: opB = arSigned;
      bMagic:    opB = magicExt;
      default:   opB = sc;
    endcase
  end

  scadAlu #(
    .ExpWidth(ExpWidth)
  ) alu_i (
    .func  (cmd.func),
    .a     (opA),
    .b     (opB),
    .result(scad)
  );

  assign scadZero = (scad == '0);

  always_comb begin
    unique case (cmd.scSel)
      scFe:    scNext = fe;
      scScad:  scNext = scad;
      scAr:    scNext = arSc;
      default: scNext = sc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fe <= '0;
      sc <= '0;
    end else begin
      if (cmd.feLoad) begin
        fe <= scad;
      end
      sc <= scNext;
    end
  end

endmodule

//--- logic/pcFlags.sv
`timescale 1ns/1ps

module pcFlags
  import scdPkg::*;
  import scdFlagPkg::*;
(
  input  logic               clk,
  input  logic               rstN,
  input  flagCmdT            cmd,
  input  logic [0:ArWidth-1] ar,
  output pcFlagsT            flags
);

  logic    setAd;
  logic    setMagic;
  pcFlagsT loaded;
  pcFlagsT setTerms;
  pcFlagsT kept;
  pcFlagsT flagsNext;

  // Set strobes are blocked during a PI cycle
  assign setAd    = cmd.setAdFlags & ~cmd.piCycle;
  assign setMagic = cmd.pcfMagic & ~cmd.piCycle;

  // Flag word layout in AR
  always_comb begin
    loaded.ov     = ar[0];
    loaded.cry0   = ar[1];
    loaded.cry1   = ar[2];
    loaded.fov    = ar[3];
    loaded.fpd    = ar[4];
    loaded.fxu    = ar[11];
    loaded.divChk = ar[12];
  end

  always_comb begin
    setTerms.ov     = (setAd & cmd.adOverflow) | (setMagic & cmd.magic[0]);
    setTerms.cry0   = setAd & cmd.adCry0;
    setTerms.cry1   = setAd & cmd.adCry1;
    // Floating overflow also sets plain overflow through magic bit 0
    setTerms.fov    = setMagic & cmd.magic[0];
    setTerms.fxu    = setMagic & cmd.magic[5];
    setTerms.divChk = setMagic & cmd.magic[6];
    setTerms.fpd    = setMagic & cmd.magic[2];
  end

  // Old state, with fpd dropped first on a clear
  always_comb begin
    kept     = flags;
    kept.fpd = flags.fpd & ~cmd.clrFpd;
  end

  always_comb begin
    if (cmd.loadFlags) begin
      flagsNext = loaded;
    end else begin
      flagsNext = kept | setTerms;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

endmodule

//--- logic/scadAlu.sv
`timescale 1ns/1ps

module scadAlu
  import scdPkg::*;
#(
  parameter int ExpWidth = ExpWidthDefault
) (
  input  scadFuncT              func,
  input  logic [ExpWidth-1:0]   a,
  input  logic [ExpWidth-1:0]   b,
  output logic [ExpWidth-1:0]   result
);

  logic [ExpWidth-1:0] bInv;

  assign bInv = ~b;

  // All arithmetic wraps at the datapath width
  always_comb begin
    unique case (func)
      funcA: begin
        result = a;
      end
      funcAMinusBMinus1: begin
        // Complement of B with no carry in
        result = a + bInv;
      end
      funcAPlusB: begin
        result = a + b;
      end
      funcAMinus1: begin
        result = a - ExpWidth'(1);
      end
      funcAPlus1: begin
        result = a + ExpWidth'(1);
      end
      funcAMinusB: begin
        // Same adder path as A-B-1 with carry in set
        result = a + bInv + ExpWidth'(1);
      end
      funcOr: begin
        result = a | b;
      end
      funcAnd: begin
        result = a & b;
      end
      default: begin
        result = a;
      end
    endcase
  end

endmodule

//--- logic/scdFlagPkg.sv
package scdFlagPkg;

  // Width of the diagnostic read word
  localparam int DiagWidth = 12;

  // Program flags, ov in the top bit down to fpd in bit 0
  typedef struct packed {
    logic ov;
    logic cry0;
    logic cry1;
    logic fov;
    logic fxu;
    logic divChk;
    logic fpd;
  } pcFlagsT;

  // Per-cycle flag strobes from microcode and the adder
  typedef struct packed {
    logic       setAdFlags;
    logic       adOverflow;
    logic       adCry0;
    logic       adCry1;
    logic       loadFlags;
    logic       pcfMagic;
    logic       clrFpd;
    logic       piCycle;
    logic [0:8] magic;
  } flagCmdT;

  // Diagnostic read selects, unlisted codes read zero
  typedef enum logic [2:0] {
    diagFe    = 3'd0,
    diagSc    = 3'd1,
    diagFlags = 3'd2,
    diagScad  = 3'd3
  } diagSelT;

endpackage

//--- logic/scdPkg.sv
package scdPkg;

  // Exponent datapath width used unless the top level overrides it
  localparam int ExpWidthDefault = 10;

  // AR word, numbered 0..35 from the left
  localparam int ArWidth = 36;

  // SCAD microcode functions
  typedef enum logic [2:0] {
    funcA             = 3'd0,
    funcAMinusBMinus1 = 3'd1,
    funcAPlusB        = 3'd2,
    funcAMinus1       = 3'd3,
    funcAPlus1        = 3'd4,
    funcAMinusB       = 3'd5,
    funcOr            = 3'd6,
    funcAnd           = 3'd7
  } scadFuncT;

  // SCAD A operand sources
  typedef enum logic [2:0] {
    aFe,
    aArPos,
    aArExp,
    aMagic,
    aZero
  } scadASelT;

  // SCAD B operand sources
  typedef enum logic [1:0] {
    bSc,
    bArSize,
    bArSigned,
    bMagic
  } scadBSelT;

  // SC load sources
  typedef enum logic [1:0] {
    scHold,
    scFe,
    scScad,
    scAr
  } scSelT;

  // Exponent microcode fields, magic numbered like the CRAM field
  typedef struct packed {
    scadFuncT   func;
    scadASelT   aSel;
    scadBSelT   bSel;
    logic       feLoad;
    scSelT      scSel;
    logic [0:8] magic;
  } expCmdT;

endpackage

//--- logic/scdTop.sv
`timescale 1ns/1ps

module scdTop
  import scdPkg::*;
  import scdFlagPkg::*;
#(
  parameter int ExpWidth = ExpWidthDefault
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  expCmdT               expCmd,
  input  flagCmdT              flagCmd,
  input  logic [0:ArWidth-1]   ar,
  input  logic                 diagRead,
  input  diagSelT              diagSel,
  output logic [ExpWidth-1:0]  scad,
  output logic                 scadZero,
  output logic [ExpWidth-1:0]  fe,
  output logic [ExpWidth-1:0]  sc,
  output pcFlagsT              flags,
  output logic [DiagWidth-1:0] diagData
);

  expDatapath #(
    .ExpWidth(ExpWidth)
  ) datapath_i (
    .clk     (clk),
    .rstN    (rstN),
    .cmd     (expCmd),
    .ar      (ar),
    .scad    (scad),
    .scadZero(scadZero),
    .fe      (fe),
    .sc      (sc)
  );

  pcFlags flags_i (
    .clk  (clk),
    .rstN (rstN),
    .cmd  (flagCmd),
    .ar   (ar),
    .flags(flags)
  );

  diagReader #(
    .ExpWidth(ExpWidth)
  ) diag_i (
    .fe      (fe),
    .sc      (sc),
    .scad    (scad),
    .flags   (flags),
    .diagRead(diagRead),
    .diagSel (diagSel),
    .diagData(diagData)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the scdTb testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --top-module scdTb -f flist.f -o scdSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/scdSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "STATUS: PASS" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1
